// File: design/ifu_pkg.sv
package ifu_pkg;

  // Address and data width of the fetch path.
  localparam int xlen = 32;

  // Cache geometry as log2 values. Two words per line, four sets.
  localparam int line_len = 1;
  localparam int index_len = 2;

  // Byte address bits below a word.
  localparam int offset_lsb = 2;

  // Address bits left above index and offset.
  localparam int tag_width = xlen - index_len - line_len - offset_lsb;

  // First fetch address after reset.
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0020;

  // Refill FSM of the instruction cache.
  localparam int state_width = 3;
  localparam logic [state_width-1:0] st_idle = 3'd0;
  localparam logic [state_width-1:0] st_beat0 = 3'd1;
  localparam logic [state_width-1:0] st_gap = 3'd2;
  localparam logic [state_width-1:0] st_beat1 = 3'd3;
  localparam logic [state_width-1:0] st_fill = 3'd4;

endpackage

// File: design/inst_pkg.sv
package inst_pkg;

  // Register-register format.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields;

  // Register-immediate format, shared by loads.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields;

  // One instruction word, read in either format.
  typedef union packed {
    r_fields r;
    i_fields i;
  } inst_word_t;

  // Major opcodes handled by the decoder.
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_load = 7'b0000011;

  // Instruction classes reported on the decode port.
  localparam logic [1:0] class_other = 2'd0;
  localparam logic [1:0] class_reg = 2'd1;
  localparam logic [1:0] class_imm = 2'd2;
  localparam logic [1:0] class_load = 2'd3;

endpackage

// File: design/fetch_resp_if.sv
interface fetch_resp_if;
  import ifu_pkg::*;
  import inst_pkg::*;

  // Four-phase handshake from the cache output slot to the decoder.
  logic            req;
  logic            ack;
  logic [xlen-1:0] pc;
  inst_word_t      inst;

  modport cache (
    output req,
    output pc,
    output inst,
    input  ack
  );

  modport decoder (
    input  req,
    input  pc,
    input  inst,
    output ack
  );

endinterface

// File: design/pc_sequencer.sv
module pc_sequencer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     redirect,
  input  logic [ifu_pkg::xlen-1:0] redirect_pc,
  output logic                     fetch_req,
  output logic [ifu_pkg::xlen-1:0] fetch_pc,
  input  logic                     fetch_ack
);
  import ifu_pkg::*;

  logic [xlen-1:0] next_pc;
  logic            redir_pending;
  logic [xlen-1:0] redir_target;
  logic            start;
  logic [xlen-1:0] start_pc;

  // A new request begins only once the previous handshake has closed.
  assign start = !fetch_req && !fetch_ack;

  // The newest redirect wins over an older captured one.
  always_comb begin
    if (redirect) begin
      start_pc = redirect_pc;
    end else if (redir_pending) begin
      start_pc = redir_target;
    end else begin
      start_pc = next_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_req <= 1'b0;
      next_pc <= reset_pc;
      redir_pending <= 1'b0;
    end else if (start) begin
      fetch_req <= 1'b1;
      next_pc <= start_pc + xlen'(4);
      redir_pending <= 1'b0;
    end else begin
      if (fetch_req && fetch_ack) begin
        fetch_req <= 1'b0;
      end
      // Held until the next request starts.
      if (redirect) begin
        redir_pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (redirect) begin
      redir_target <= redirect_pc;
    end
    if (start) begin
      fetch_pc <= start_pc;
    end
  end

endmodule

// File: design/l1i_cache.sv
module l1i_cache (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     fetch_req,
  input  logic [ifu_pkg::xlen-1:0] fetch_pc,
  output logic                     fetch_ack,
  input  logic                     invalidate,
  output logic [ifu_pkg::xlen-1:0] mem_araddr,
  output logic                     mem_arvalid,
  input  logic                     mem_rvalid,
  input  logic [ifu_pkg::xlen-1:0] mem_rdata,
  fetch_resp_if.cache              resp
);
  import ifu_pkg::*;

  logic [xlen-1:0]         data_q [2**index_len][2**line_len];
  logic [tag_width-1:0]    tag_q [2**index_len];
  logic [2**index_len-1:0] valid_q;

  logic [state_width-1:0] state;
  logic                   inval_pending;
  logic                   slot_full;

  logic [tag_width-1:0] addr_tag;
  logic [index_len-1:0] addr_idx;
  logic [line_len-1:0]  addr_off;
  logic [line_len-1:0]  beat;
  logic                 new_req;
  logic                 hit;
  logic                 serve;

  assign addr_tag = fetch_pc[xlen-1 -: tag_width];
  assign addr_idx = fetch_pc[offset_lsb+line_len +: index_len];
  assign addr_off = fetch_pc[offset_lsb +: line_len];

  // A request stays new until it has been acknowledged.
  assign new_req = fetch_req && !fetch_ack;
  assign hit = valid_q[addr_idx] && (tag_q[addr_idx] == addr_tag);

  // Serve once the line is present and the output slot is empty.
  assign serve = new_req && !slot_full &&
                 ((state == st_idle && hit && !inval_pending) || state == st_fill);

  // Beat 0 reads the even word of the line, beat 1 the odd word.
  assign beat = line_len'(state == st_beat1);
  assign mem_araddr = {fetch_pc[xlen-1:offset_lsb+line_len], beat, {offset_lsb{1'b0}}};
  assign mem_arvalid = (state == st_beat0) || (state == st_beat1);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      valid_q <= '0;
      inval_pending <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (inval_pending) begin
            // Like fence.i, drop every line before the next lookup.
            valid_q <= '0;
            inval_pending <= 1'b0;
          end else if (new_req && !hit) begin
            state <= st_beat0;
          end
        end
        st_beat0: begin
          if (mem_rvalid) begin
            valid_q[addr_idx] <= 1'b0;
            state <= st_gap;
          end
        end
        st_gap: begin
          state <= st_beat1;
        end
        st_beat1: begin
          if (mem_rvalid) begin
            valid_q[addr_idx] <= 1'b1;
            state <= st_fill;
          end
        end
        st_fill: begin
          // Wait here for a free slot so the refilled word is served first.
          if (serve) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
      if (invalidate) begin
        inval_pending <= 1'b1;
      end
    end
  end

  // Producer side of the fetch handshake.
  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_ack <= 1'b0;
    end else if (serve) begin
      fetch_ack <= 1'b1;
    end else if (fetch_ack && !fetch_req) begin
      fetch_ack <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_arvalid && mem_rvalid) begin
      data_q[addr_idx][beat] <= mem_rdata;
    end
    if (state == st_beat1 && mem_rvalid) begin
      tag_q[addr_idx] <= addr_tag;
    end
  end

  // Output slot towards the decoder.
  always_ff @(posedge clock) begin
    if (reset) begin
      slot_full <= 1'b0;
      resp.req <= 1'b0;
    end else if (serve) begin
      slot_full <= 1'b1;
      resp.req <= 1'b1;
    end else if (resp.req && resp.ack) begin
      resp.req <= 1'b0;
    end else if (slot_full && !resp.req && !resp.ack) begin
      // ack has fallen, so the word is consumed.
      slot_full <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (serve) begin
      resp.pc <= fetch_pc;
      resp.inst <= data_q[addr_idx][addr_off];
    end
  end

endmodule

// File: design/inst_decoder.sv
module inst_decoder (
  input  logic                     clock,
  input  logic                     reset,
  fetch_resp_if.decoder            resp,
  input  logic                     dec_stall,
  output logic                     dec_valid,
  output logic [ifu_pkg::xlen-1:0] dec_pc,
  output logic [1:0]               dec_class,
  output logic [4:0]               dec_rd,
  output logic [4:0]               dec_rs1,
  output logic [31:0]              dec_imm
);
  import inst_pkg::*;

  logic        take;
  logic [1:0]  cls;
  logic [31:0] imm;
  logic [31:0] sext_imm;

  // Accept a word only while not stalled and before acknowledging it.
  assign take = resp.req && !resp.ack && !dec_stall;

  assign sext_imm = {{20{resp.inst.i.imm12[11]}}, resp.inst.i.imm12};

  always_comb begin
    cls = class_other;
    imm = '0;
    case (resp.inst.r.opcode)
      op_reg: begin
        cls = class_reg;
      end
      op_imm: begin
        cls = class_imm;
        imm = sext_imm;
      end
      op_load: begin
        cls = class_load;
        imm = sext_imm;
      end
      default: begin
        cls = class_other;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      resp.ack <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= take;
      if (take) begin
        resp.ack <= 1'b1;
      end else if (resp.ack && !resp.req) begin
        resp.ack <= 1'b0;
      end
    end
  end

  // rd and rs1 sit at the same bits in every format.
  always_ff @(posedge clock) begin
    if (take) begin
      dec_pc <= resp.pc;
      dec_class <= cls;
      dec_rd <= resp.inst.r.rd;
      dec_rs1 <= resp.inst.r.rs1;
      dec_imm <= imm;
    end
  end

endmodule

// File: design/ifu_top.sv
module ifu_top (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     redirect,
  input  logic [ifu_pkg::xlen-1:0] redirect_pc,
  input  logic                     invalidate,
  input  logic                     dec_stall,
  output logic [ifu_pkg::xlen-1:0] mem_araddr,
  output logic                     mem_arvalid,
  input  logic                     mem_rvalid,
  input  logic [ifu_pkg::xlen-1:0] mem_rdata,
  output logic                     dec_valid,
  output logic [ifu_pkg::xlen-1:0] dec_pc,
  output logic [1:0]               dec_class,
  output logic [4:0]               dec_rd,
  output logic [4:0]               dec_rs1,
  output logic [31:0]              dec_imm
);
  import ifu_pkg::*;

  logic            fetch_req;
  logic [xlen-1:0] fetch_pc;
  logic            fetch_ack;

  fetch_resp_if resp_if ();

  pc_sequencer pc_sequencer_i (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_req   (fetch_req),
    .fetch_pc    (fetch_pc),
    .fetch_ack   (fetch_ack)
  );

  l1i_cache l1i_cache_i (
    .clock       (clock),
    .reset       (reset),
    .fetch_req   (fetch_req),
    .fetch_pc    (fetch_pc),
    .fetch_ack   (fetch_ack),
    .invalidate  (invalidate),
    .mem_araddr  (mem_araddr),
    .mem_arvalid (mem_arvalid),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .resp        (resp_if)
  );

  inst_decoder inst_decoder_i (
    .clock     (clock),
    .reset     (reset),
    .resp      (resp_if),
    .dec_stall (dec_stall),
    .dec_valid (dec_valid),
    .dec_pc    (dec_pc),
    .dec_class (dec_class),
    .dec_rd    (dec_rd),
    .dec_rs1   (dec_rs1),
    .dec_imm   (dec_imm)
  );

endmodule

// File: verif/ifu_tb.sv
module ifu_tb;
  import ifu_pkg::*;
  import inst_pkg::*;

  logic            clock;
  logic            reset;
  logic            redirect;
  logic [xlen-1:0] redirect_pc;
  logic            invalidate;
  logic            dec_stall;
  logic [xlen-1:0] mem_araddr;
  logic            mem_arvalid;
  logic            mem_rvalid;
  logic [xlen-1:0] mem_rdata;
  logic            dec_valid;
  logic [xlen-1:0] dec_pc;
  logic [1:0]      dec_class;
  logic [4:0]      dec_rd;
  logic [4:0]      dec_rs1;
  logic [31:0]     dec_imm;

  logic [31:0] mem [logic [31:0]];
  byte         cmd_kind [$];
  logic [31:0] cmd_addr [$];
  int          cmd_count [$];
  int          cmd_reads [$];

  int          cycle_count;
  int          cycle_limit;
  int          error_count;
  int          decode_count;
  int          after_target;
  logic [31:0] expected_pc;
  logic        armed;
  logic [31:0] target;
  logic        stall_check;
  logic [31:0] dec_word;

  // Memory model state.
  logic        mem_busy;
  int          mem_wait;
  logic [31:0] mem_addr_q;
  logic        odd_beat;
  logic [31:0] line_base;
  logic        window_active;
  logic [31:0] window_lo;
  logic [31:0] window_hi;
  int          window_reads;

  ifu_top dut_i (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .invalidate  (invalidate),
    .dec_stall   (dec_stall),
    .mem_araddr  (mem_araddr),
    .mem_arvalid (mem_arvalid),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .dec_valid   (dec_valid),
    .dec_pc      (dec_pc),
    .dec_class   (dec_class),
    .dec_rd      (dec_rd),
    .dec_rs1     (dec_rs1),
    .dec_imm     (dec_imm)
  );

  always #5 clock = !clock;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // Words outside the image get a pattern that mixes every address bit.
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return fill_word(addr);
  endfunction

  function automatic logic [1:0] ref_class(input logic [31:0] w);
    case (w[6:0])
      op_reg:  return class_reg;
      op_imm:  return class_imm;
      op_load: return class_load;
      default: return class_other;
    endcase
  endfunction

  function automatic logic [31:0] ref_imm(input logic [31:0] w);
    if (w[6:0] == op_imm || w[6:0] == op_load) begin
      return {{20{w[31]}}, w[31:20]};
    end
    return 32'h0;
  endfunction

  task automatic load_testdata();
    int          fd;
    int          n;
    string       tok;
    string       line;
    logic [31:0] a;
    logic [31:0] w;
    int          c;
    int          r;
    fd = $fopen("verif/ifu_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file verif/ifu_testdata.txt");
      $display("CHECKS FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %s", tok);
      if (n != 1) begin
        break;
      end
      if (tok[0] == "#") begin
        void'($fgets(line, fd));
      end else if (tok == "M") begin
        n = $fscanf(fd, " %h %h", a, w);
        mem[a] = w;
      end else if (tok == "R") begin
        n = $fscanf(fd, " %h %d %d", a, c, r);
        cmd_kind.push_back("R");
        cmd_addr.push_back(a);
        cmd_count.push_back(c);
        cmd_reads.push_back(r);
      end else if (tok == "C" || tok == "S") begin
        n = $fscanf(fd, " %d", c);
        cmd_kind.push_back(tok[0]);
        cmd_addr.push_back(32'h0);
        cmd_count.push_back(c);
        cmd_reads.push_back(0);
      end else begin
        cmd_kind.push_back("I");
        cmd_addr.push_back(32'h0);
        cmd_count.push_back(0);
        cmd_reads.push_back(0);
      end
    end
    $fclose(fd);
  endtask

  // Memory model with a random latency of 1 to 4 cycles per read.
  always @(posedge clock) begin
    mem_rvalid <= 1'b0;
    if (!reset) begin
      if (mem_busy) begin
        if (mem_wait <= 1) begin
          mem_rvalid <= 1'b1;
          mem_rdata <= mem_word(mem_addr_q);
          mem_busy <= 1'b0;
          if (window_active && mem_addr_q >= window_lo && mem_addr_q < window_hi) begin
            window_reads++;
          end
        end else begin
          mem_wait <= mem_wait - 1;
        end
      end else if (mem_arvalid && !mem_rvalid) begin
        // Beats come in pairs, even word then odd word of one line.
        if (!odd_beat) begin
          check_value("refill beat 0 address", {mem_araddr[31:3], 3'b000}, mem_araddr);
          line_base <= mem_araddr;
        end else begin
          check_value("refill beat 1 address", line_base + 32'd4, mem_araddr);
        end
        odd_beat <= !odd_beat;
        mem_addr_q <= mem_araddr;
        mem_wait <= int'($urandom_range(1, 4));
        mem_busy <= 1'b1;
      end
    end
  end

  // Decode stream monitor, sampled away from the active edge.
  always @(negedge clock) begin
    if (!reset) begin
      if (stall_check) begin
        check_value("dec_valid during stall", 32'h0, 32'(dec_valid));
      end
      if (dec_valid) begin
        if (armed && dec_pc == target) begin
          armed = 1'b0;
          after_target = 0;
        end else begin
          check_value("pc sequence", expected_pc, dec_pc);
        end
        expected_pc = dec_pc + 32'd4;
        dec_word = mem_word(dec_pc);
        check_value("decode class", 32'(ref_class(dec_word)), 32'(dec_class));
        check_value("decode rd", {27'h0, dec_word[11:7]}, 32'(dec_rd));
        check_value("decode rs1", {27'h0, dec_word[19:15]}, 32'(dec_rs1));
        check_value("decode imm", ref_imm(dec_word), dec_imm);
        decode_count++;
        if (!armed) begin
          after_target++;
        end
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the decode stream stopped before the script finished");
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  initial begin
    int total;
    int goal;
    void'($urandom(69));
    clock = 1'b0;
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    invalidate = 1'b0;
    dec_stall = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    mem_busy = 1'b0;
    mem_wait = 0;
    mem_addr_q = '0;
    odd_beat = 1'b0;
    line_base = '0;
    window_active = 1'b0;
    window_lo = '0;
    window_hi = '0;
    window_reads = 0;
    cycle_count = 0;
    cycle_limit = 1000000;
    error_count = 0;
    decode_count = 0;
    after_target = 0;
    expected_pc = reset_pc;
    armed = 1'b0;
    target = '0;
    stall_check = 1'b0;
    dec_word = '0;
    load_testdata();
    total = 0;
    foreach (cmd_kind[k]) begin
      // Stall windows add no decodes.
      if (cmd_kind[k] != "S") begin
        total += cmd_count[k];
      end
    end
    cycle_limit = total * 200 + 1000;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    foreach (cmd_kind[k]) begin
      case (cmd_kind[k])
        "C": begin
          goal = decode_count + cmd_count[k];
          wait (decode_count >= goal);
          @(posedge clock);
        end
        "R": begin
          armed = 1'b1;
          target = cmd_addr[k];
          window_lo = cmd_addr[k];
          window_hi = cmd_addr[k] + 32'(cmd_count[k] * 4);
          window_reads = 0;
          window_active = 1'b1;
          redirect <= 1'b1;
          redirect_pc <= cmd_addr[k];
          @(posedge clock);
          redirect <= 1'b0;
          wait (!armed && after_target >= cmd_count[k]);
          check_value("memory reads in loop", 32'(cmd_reads[k]), 32'(window_reads));
          window_active = 1'b0;
          @(posedge clock);
        end
        "S": begin
          dec_stall <= 1'b1;
          @(posedge clock);
          stall_check = 1'b1;
          repeat (cmd_count[k]) @(posedge clock);
          stall_check = 1'b0;
          dec_stall <= 1'b0;
          @(posedge clock);
        end
        default: begin
          invalidate <= 1'b1;
          @(posedge clock);
          invalidate <= 1'b0;
          @(posedge clock);
        end
      endcase
    end
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: verif/ifu_testdata.txt
# M <word address hex> <instruction hex> fills the memory image.
# Script: R <target hex> <decodes> <loop reads>, I, S <stall cycles>, C <decodes>.
M 00000020 fff00093
M 00000024 002081b3
M 00000028 ff812283
M 0000002c 12345337
M 00000030 7ff38393
M 00000034 40a48433
M 00000038 04062583
M 0000003c 0080006f
M 00000100 80050513
M 00000104 00c5f5b3
M 00000108 ffc72683
M 0000010c fe000ee3
# Straight-line fetch from the reset address.
C 8
# First pass over the loop misses on both lines.
R 00000100 4 4
# Second pass hits.
R 00000100 4 0
S 12
C 5
# Invalidate, then the loop refills.
I
R 00000100 4 4
S 6
# Both lines were evicted by the loop.
R 00000020 4 4
C 3

// File: sim.f
design/ifu_pkg.sv
design/inst_pkg.sv
design/fetch_resp_if.sv
design/pc_sequencer.sv
design/l1i_cache.sv
design/inst_decoder.sv
design/ifu_top.sv
verif/ifu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module ifu_tb -f sim.f --Mdir obj_dir -o ifu_sim

./obj_dir/ifu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  exit 1
fi
